/* compile.f */
+incdir+include
logic/bram_fifo_pkg.sv
logic/fifo_ram_dualport.sv
logic/fifo_lutram.sv
logic/bram_fifo_ctrl.sv
logic/bram_fifo_data.sv
logic/wb_push_port.sv
logic/wb_pop_port.sv
logic/wb_bram_fifo_top.sv
tests/wb_bram_fifo_assertions.sv
tests/wb_bram_fifo_tb.sv

/* tests/wb_bram_fifo_tb.sv */
// Testbench for the Wishbone BRAM FIFO: clock, reset, LFSR, bus tasks, model and checks
`timescale 1ns/1ns
`include "bram_fifo_defines.svh"

module wb_bram_fifo_tb
    import bram_fifo_pkg::*;
;

    // Words held with pops idle, main store plus output stage
    localparam int TOTAL_DEPTH = `FIFO_DEPTH + `OUT_FIFO_DEPTH;
    localparam int ACK_TIMEOUT = 200;
    localparam int HOLD_CYCLES = 50;

    logic clk = 1'b0;
    logic reset;
    logic push_cyc;
    logic push_stb;
    logic push_we;
    data_t push_dat_w;
    logic push_ack;
    logic pop_cyc;
    logic pop_stb;
    logic pop_we;
    data_t pop_dat_r;
    logic pop_ack;
    logic not_full;
    logic almost_full;

    // Reference model, oldest word at the front
    data_t ref_q[$];
    logic [31:0] lfsr_state = 32'h472;

    // 4 ns clock
    always #2 clk = ~clk;

    wb_bram_fifo_top wb_bram_fifo_top_i
    (
        .clk(clk),
        .reset(reset),
        .push_cyc(push_cyc),
        .push_stb(push_stb),
        .push_we(push_we),
        .push_dat_w(push_dat_w),
        .push_ack(push_ack),
        .pop_cyc(pop_cyc),
        .pop_stb(pop_stb),
        .pop_we(pop_we),
        .pop_dat_r(pop_dat_r),
        .pop_ack(pop_ack),
        .not_full(not_full),
        .almost_full(almost_full)
    );

    bind wb_bram_fifo_top wb_bram_fifo_assertions protocol_check_i
    (
        .clk(clk),
        .reset(reset),
        .push_cyc(push_cyc),
        .push_stb(push_stb),
        .push_ack(push_ack),
        .pop_cyc(pop_cyc),
        .pop_stb(pop_stb),
        .pop_ack(pop_ack),
        .enq_en(enq_en),
        .not_full(not_full)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic next_random_bit();
        logic feedback;
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    // Expected head word and flags once transfers have settled
    // Output stage fills first, the rest sits in the main store
    function automatic void predict(output data_t word, output logic exp_not_full,
                                    output logic exp_almost_full);
        int main_count;
        main_count = ref_q.size() - `OUT_FIFO_DEPTH;
        if (main_count < 0)
        begin
            main_count = 0;
        end
        word = (ref_q.size() > 0) ? ref_q[0] : '0;
        exp_not_full = (main_count < `FIFO_DEPTH);
        exp_almost_full = (main_count >= `FIFO_DEPTH - `FIFO_THRESHOLD);
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flags();
        data_t word;
        logic exp_nf;
        logic exp_af;
        predict(word, exp_nf, exp_af);
        check_flag("not_full", not_full, exp_nf);
        check_flag("almost_full", almost_full, exp_af);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic push_start(input data_t word);
        @(negedge clk);
        push_cyc = 1'b1;
        push_stb = 1'b1;
        push_we = 1'b1;
        push_dat_w = word;
    endtask

    // Wait for ack, record the word, end the cycle
    task automatic push_finish(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (push_ack !== 1'b1)
        begin
            cycles++;
            if (cycles > limit)
            begin
                fail_run("Push was not acknowledged before its timeout");
            end
            @(negedge clk);
        end
        ref_q.push_back(push_dat_w);
        push_cyc = 1'b0;
        push_stb = 1'b0;
        push_we = 1'b0;
    endtask

    task automatic push_word(input data_t word);
        push_start(word);
        push_finish(ACK_TIMEOUT);
    endtask

    task automatic pop_start();
        @(negedge clk);
        pop_cyc = 1'b1;
        pop_stb = 1'b1;
        pop_we = 1'b0;
    endtask

    task automatic pop_release();
        pop_cyc = 1'b0;
        pop_stb = 1'b0;
    endtask

    // Data is checked by the compare process on the ack
    task automatic pop_word();
        int cycles;
        cycles = 0;
        pop_start();
        @(negedge clk);
        while (pop_ack !== 1'b1)
        begin
            cycles++;
            if (cycles > ACK_TIMEOUT)
            begin
                fail_run("Pop was not acknowledged before its timeout");
            end
            @(negedge clk);
        end
        pop_release();
    endtask

    // Every pop ack against the model head
    always @(negedge clk)
    begin : compare_pops
        data_t exp_word;
        logic exp_nf;
        logic exp_af;
        if (!reset && pop_ack === 1'b1)
        begin
            if (ref_q.size() == 0)
            begin
                fail_run("Pop acknowledged while the reference model is empty");
            end
            predict(exp_word, exp_nf, exp_af);
            check_data("pop_dat_r", pop_dat_r, exp_word);
            ref_q.delete(0);
        end
    end

    always @(negedge clk)
    begin
        if (wb_bram_fifo_top_i.protocol_check_i.violations != 0)
        begin
            fail_run("A bound protocol assertion failed");
        end
    end

    initial
    begin
        reset = 1'b1;
        push_cyc = 1'b0;
        push_stb = 1'b0;
        push_we = 1'b0;
        push_dat_w = '0;
        pop_cyc = 1'b0;
        pop_stb = 1'b0;
        pop_we = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Empty buffer, pop must stall
        @(negedge clk);
        check_flags();
        pop_start();
        repeat (HOLD_CYCLES)
        begin
            @(negedge clk);
            if (pop_ack === 1'b1)
            begin
                fail_run("Pop on the empty buffer was acknowledged");
            end
        end
        pop_release();

        // Random words with random gaps on both sides
        fork
            for (int i = 0; i < 40; i++)
            begin
                push_word(random_bits(32));
                idle_cycles(random_bits(3));
            end
            for (int i = 0; i < 40; i++)
            begin
                pop_word();
                idle_cycles(random_bits(3));
            end
        join

        // Fill to capacity, then one more push must hold
        for (int i = 0; i < TOTAL_DEPTH; i++)
        begin
            push_word(random_bits(32));
        end
        push_start(random_bits(32));
        repeat (HOLD_CYCLES)
        begin
            @(negedge clk);
            if (push_ack === 1'b1)
            begin
                fail_run("Push into the full buffer was acknowledged");
            end
        end
        check_flags();

        // One pop frees a slot for the held push
        fork
            push_finish(ACK_TIMEOUT);
            pop_word();
        join

        // Drain all
        for (int i = 0; i < TOTAL_DEPTH; i++)
        begin
            pop_word();
        end
        // One more edge so the last pop has left the model
        @(negedge clk);
        if (ref_q.size() != 0)
        begin
            fail_run("Reference model not empty after the drain");
        end
        check_flags();

        // Concurrent traffic around half occupancy
        for (int i = 0; i < TOTAL_DEPTH / 2; i++)
        begin
            push_word(random_bits(32));
        end
        fork
            for (int i = 0; i < 300; i++)
            begin
                push_word(random_bits(32));
                idle_cycles(random_bits(2));
            end
            for (int i = 0; i < 300; i++)
            begin
                pop_word();
                idle_cycles(random_bits(2));
            end
        join
        for (int i = 0; i < TOTAL_DEPTH / 2; i++)
        begin
            pop_word();
        end
        check_flags();

        @(negedge clk);
        if (wb_bram_fifo_top_i.protocol_check_i.violations == 0)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
        begin
            fail_run("A bound protocol assertion failed before the end of the run");
        end
    end

endmodule

/* tests/wb_bram_fifo_assertions.sv */
// Bound protocol assertions for both Wishbone ports and the enqueue strobe
`timescale 1ns/1ns

module wb_bram_fifo_assertions
(
    input  logic clk,
    input  logic reset,
    input  logic push_cyc,
    input  logic push_stb,
    input  logic push_ack,
    input  logic pop_cyc,
    input  logic pop_stb,
    input  logic pop_ack,
    input  logic enq_en,
    input  logic not_full
);

    // Failed assertions so far, read by the testbench
    int violations = 0;

    // Ack only answers a cycle and strobe seen at the previous edge
    push_ack_has_stb: assert property (@(posedge clk) disable iff (reset)
        push_ack |-> $past(push_cyc && push_stb))
    else
    begin
        $error("push ack without cyc and stb");
        violations++;
    end

    pop_ack_has_stb: assert property (@(posedge clk) disable iff (reset)
        pop_ack |-> $past(pop_cyc && pop_stb))
    else
    begin
        $error("pop ack without cyc and stb");
        violations++;
    end

    // One ack cycle per bus cycle
    push_ack_single: assert property (@(posedge clk) disable iff (reset)
        push_ack |=> !push_ack)
    else
    begin
        $error("push ack longer than one cycle");
        violations++;
    end

    pop_ack_single: assert property (@(posedge clk) disable iff (reset)
        pop_ack |=> !pop_ack)
    else
    begin
        $error("pop ack longer than one cycle");
        violations++;
    end

    // No enqueue into a full main store
    enq_not_when_full: assert property (@(posedge clk) disable iff (reset)
        enq_en |-> not_full)
    else
    begin
        $error("enq_en high while not_full is low");
        violations++;
    end

endmodule

/* logic/wb_bram_fifo_top.sv */
// Top level of the Wishbone BRAM FIFO: push port, control, data and pop port
`timescale 1ns/1ns
`include "bram_fifo_defines.svh"

module wb_bram_fifo_top
    import bram_fifo_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Push bus
    input  logic push_cyc,
    input  logic push_stb,
    input  logic push_we,
    input  logic [`FIFO_DATA_W-1:0] push_dat_w,
    output logic push_ack,

    // Pop bus
    input  logic pop_cyc,
    input  logic pop_stb,
    input  logic pop_we,
    output logic [`FIFO_DATA_W-1:0] pop_dat_r,
    output logic pop_ack,

    // Main store flags
    output logic not_full,
    output logic almost_full
);

    // Push port to control and data halves
    logic enq_en;
    data_t enq_data;
    idx_t enq_idx;

    // Control half to data half
    logic first_rdy;
    logic first_deq;
    idx_t first_idx;

    // Data half to pop port
    logic not_empty;
    data_t first;
    logic deq_en;

    wb_push_port push_port_i
    (
        .clk(clk),
        .reset(reset),
        .cyc(push_cyc),
        .stb(push_stb),
        .we(push_we),
        .dat_w(push_dat_w),
        .ack(push_ack),
        .not_full(not_full),
        .enq_en(enq_en),
        .enq_data(enq_data)
    );

    bram_fifo_ctrl ctrl_i
    (
        .clk(clk),
        .reset(reset),
        .enq_en(enq_en),
        .enq_idx(enq_idx),
        .not_full(not_full),
        .almost_full(almost_full),
        .first_deq(first_deq),
        .first_rdy(first_rdy),
        .first_idx(first_idx)
    );

    bram_fifo_data data_i
    (
        .clk(clk),
        .reset(reset),
        .enq_en(enq_en),
        .enq_idx(enq_idx),
        .enq_data(enq_data),
        .first_rdy(first_rdy),
        .first_idx(first_idx),
        .first_deq(first_deq),
        .deq_en(deq_en),
        .not_empty(not_empty),
        .first(first)
    );

    wb_pop_port pop_port_i
    (
        .clk(clk),
        .reset(reset),
        .cyc(pop_cyc),
        .stb(pop_stb),
        .we(pop_we),
        .dat_r(pop_dat_r),
        .ack(pop_ack),
        .not_empty(not_empty),
        .first(first),
        .deq_en(deq_en)
    );

endmodule

/* logic/wb_pop_port.sv */
// Wishbone classic slave on the pop side, returns and dequeues the oldest word
`timescale 1ns/1ns

module wb_pop_port
    import bram_fifo_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Wishbone slave
    input  logic cyc,
    input  logic stb,
    input  logic we,
    output data_t dat_r,
    output logic ack,

    // FIFO dequeue side
    input  logic not_empty,
    input  data_t first,
    output logic deq_en
);

    wb_state_t state;
    logic accept;

    // Reads wait here while the output stage is empty
    assign accept = (state == wb_idle) && cyc && stb && !we && not_empty;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= wb_idle;
        end
        else
        begin
            case (state)
                wb_idle:
                begin
                    if (accept)
                    begin
                        state <= wb_ack;
                    end
                end
                default:
                begin
                    // Ack is one cycle wide
                    state <= wb_idle;
                end
            endcase
        end
    end

    // Oldest word captured at accept
    // first cannot move before the dequeue, so dat_r matches what is removed
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            dat_r <= first;
        end
    end

    assign ack = (state == wb_ack);
    assign deq_en = ack;

endmodule

/* logic/wb_push_port.sv */
// Wishbone classic slave on the push side, one enqueue per acknowledged write
`timescale 1ns/1ns

module wb_push_port
    import bram_fifo_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Wishbone slave
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  data_t dat_w,
    output logic ack,

    // FIFO enqueue side
    input  logic not_full,
    output logic enq_en,
    output data_t enq_data
);

    wb_state_t state;
    logic accept;

    // Take a write only when the buffer has room
    // Otherwise the master sees wait states
    assign accept = (state == wb_idle) && cyc && stb && we && not_full;

    // Single ack cycle, then back to idle while the master drops stb
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= wb_idle;
        end
        else
        begin
            case (state)
                wb_idle:
                begin
                    if (accept)
                    begin
                        state <= wb_ack;
                    end
                end
                default:
                begin
                    state <= wb_idle;
                end
            endcase
        end
    end

    // Word held for the enqueue in the ack cycle
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            enq_data <= dat_w;
        end
    end

    assign ack = (state == wb_ack);
    // Enqueue happens exactly on the ack pulse
    assign enq_en = ack;

endmodule

/* logic/bram_fifo_data.sv */
// Data half of the BRAM FIFO: main RAM store and output register FIFO
`timescale 1ns/1ns
`include "bram_fifo_defines.svh"

module bram_fifo_data
    import bram_fifo_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Writes into the main store
    input  logic enq_en,
    input  idx_t enq_idx,
    input  data_t enq_data,

    // Handshake with the control half
    input  logic first_rdy,
    input  idx_t first_idx,
    output logic first_deq,

    // Pop side, served from the output stage
    input  logic deq_en,
    output logic not_empty,
    output data_t first
);

    data_t ram_rdata;
    logic out_almost_full;
    logic out_not_full;

    // Transfers issued one and two cycles ago
    // Second stage lines up with the RAM read data
    logic xfer_q1;
    logic xfer_q2;

    // Start a RAM read while the output stage can absorb it
    // plus whatever is still in flight
    // Past the threshold, one free slot is enough once nothing is in flight
    assign first_deq = first_rdy &&
                       (!out_almost_full || (out_not_full && !xfer_q1 && !xfer_q2));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            xfer_q1 <= 1'b0;
            xfer_q2 <= 1'b0;
        end
        else
        begin
            xfer_q1 <= first_deq;
            xfer_q2 <= xfer_q1;
        end
    end

    // Main store, write at enq_idx, read at the oldest index
    fifo_ram_dualport
    #(
        .N_ENTRIES(`FIFO_DEPTH),
        .N_DATA_BITS($bits(data_t))
    )
    ram_i
    (
        .clk(clk),
        .wen(enq_en),
        .waddr(enq_idx),
        .wdata(enq_data),
        .raddr(first_idx),
        .rdata(ram_rdata)
    );

    // Output stage
    // Threshold of two keeps room for both reads in flight
    fifo_lutram
    #(
        .N_DATA_BITS($bits(data_t)),
        .N_ENTRIES(`OUT_FIFO_DEPTH),
        .THRESHOLD(2)
    )
    out_fifo_i
    (
        .clk(clk),
        .reset(reset),
        .enq_data(ram_rdata),
        .enq_en(xfer_q2),
        .not_full(out_not_full),
        .almost_full(out_almost_full),
        .first(first),
        .deq_en(deq_en),
        .not_empty(not_empty)
    );

endmodule

/* logic/bram_fifo_ctrl.sv */
// Control half of the BRAM FIFO: write and read indices, occupancy and flags
`timescale 1ns/1ns
`include "bram_fifo_defines.svh"

module bram_fifo_ctrl
    import bram_fifo_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // Enqueue side, index of the slot to write
    input  logic enq_en,
    output idx_t enq_idx,
    output logic not_full,
    output logic almost_full,

    // Transfer side toward the data half
    input  logic first_deq,
    output logic first_rdy,
    output idx_t first_idx
);

    idx_t wr_idx;
    idx_t rd_idx;
    count_t count;
    count_t count_next;

    assign enq_idx = wr_idx;
    assign first_idx = rd_idx;

    // Write index moves on each enqueue
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_idx <= '0;
        end
        else if (enq_en)
        begin
            wr_idx <= (wr_idx == idx_t'(`FIFO_DEPTH - 1)) ? '0 : wr_idx + idx_t'(1);
        end
    end

    // Read index moves each time the oldest entry leaves for the output stage
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_idx <= '0;
        end
        else if (first_deq)
        begin
            rd_idx <= (rd_idx == idx_t'(`FIFO_DEPTH - 1)) ? '0 : rd_idx + idx_t'(1);
        end
    end

    // Next occupancy
    // Simultaneous enqueue and transfer leave it unchanged
    always_comb
    begin
        count_next = count;
        if (enq_en && !first_deq)
        begin
            count_next = count + count_t'(1);
        end
        else if (first_deq && !enq_en)
        begin
            count_next = count - count_t'(1);
        end
    end

    // Flags registered from the next count, one cycle behind the event
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
            not_full <= 1'b1;
            almost_full <= 1'b0;
            first_rdy <= 1'b0;
        end
        else
        begin
            count <= count_next;
            not_full <= (count_next != count_t'(`FIFO_DEPTH));
            almost_full <= (count_next >= count_t'(`FIFO_DEPTH - `FIFO_THRESHOLD));
            first_rdy <= (count_next != '0);
        end
    end

endmodule

/* logic/fifo_lutram.sv */
// Small register FIFO with count and registered full, almost-full and empty flags
`timescale 1ns/1ns

module fifo_lutram
#(
    parameter N_DATA_BITS = 32,
    parameter N_ENTRIES = 4,
    parameter THRESHOLD = 1
)
(
    input  logic clk,
    input  logic reset,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic enq_en,
    output logic not_full,
    output logic almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic deq_en,
    output logic not_empty
);

    localparam IDX_W = $clog2(N_ENTRIES);
    localparam CNT_W = $clog2(N_ENTRIES + 1);

    logic [N_DATA_BITS-1:0] data [N_ENTRIES];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;

    // Payload array, no reset needed
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            data[wr_idx] <= enq_data;
        end
    end

    // Oldest entry, visible with no delay
    assign first = data[rd_idx];

    // Occupancy after this cycle's enq and deq
    always_comb
    begin
        count_next = count;
        if (enq_en && !deq_en)
        begin
            count_next = count + CNT_W'(1);
        end
        else if (deq_en && !enq_en)
        begin
            count_next = count - CNT_W'(1);
        end
    end

    // Indices wrap at N_ENTRIES, flags come from the next count
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_idx <= '0;
            rd_idx <= '0;
            count <= '0;
            not_full <= 1'b1;
            almost_full <= 1'b0;
            not_empty <= 1'b0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_idx <= (wr_idx == IDX_W'(N_ENTRIES - 1)) ? '0 : wr_idx + IDX_W'(1);
            end
            if (deq_en)
            begin
                rd_idx <= (rd_idx == IDX_W'(N_ENTRIES - 1)) ? '0 : rd_idx + IDX_W'(1);
            end
            count <= count_next;
            not_full <= (count_next != CNT_W'(N_ENTRIES));
            almost_full <= (count_next >= CNT_W'(N_ENTRIES - THRESHOLD));
            not_empty <= (count_next != '0);
        end
    end

endmodule

/* logic/fifo_ram_dualport.sv */
// Dual-port RAM with one write port and a two-stage registered read port
`timescale 1ns/1ns

module fifo_ram_dualport
#(
    parameter N_ENTRIES = 32,
    parameter N_DATA_BITS = 32
)
(
    input  logic clk,

    // Write port
    input  logic wen,
    input  logic [$clog2(N_ENTRIES)-1:0] waddr,
    input  logic [N_DATA_BITS-1:0] wdata,

    // Read port, data two cycles after address
    input  logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [N_DATA_BITS-1:0] rdata
);

    // Storage array, maps onto block RAM
    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

    // Address register, first read stage
    logic [$clog2(N_ENTRIES)-1:0] raddr_q;

    // Write side
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Read side
    // Stage one latches the address, stage two latches the word
    always_ff @(posedge clk)
    begin
        raddr_q <= raddr;
        rdata <= mem[raddr_q];
    end

endmodule

/* logic/bram_fifo_pkg.sv */
// Package with the FIFO word, index and count types and the bus port state enum
`include "bram_fifo_defines.svh"

package bram_fifo_pkg;

    // One data word as carried on both Wishbone ports
    typedef logic [`FIFO_DATA_W-1:0] data_t;

    // Index into the main store
    typedef logic [$clog2(`FIFO_DEPTH)-1:0] idx_t;

    // Occupancy of the main store
    // One extra bit so that both 0 and FIFO_DEPTH fit
    typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] count_t;

    // Wishbone slave port FSM, shared by push and pop sides
    typedef enum logic
    {
        wb_idle,
        wb_ack
    } wb_state_t;

endpackage

/* include/bram_fifo_defines.svh */
// Size macros for the Wishbone BRAM FIFO: word width, depths and threshold
`ifndef BRAM_FIFO_DEFINES_SVH
`define BRAM_FIFO_DEFINES_SVH

// Width of one data word on both buses
`define FIFO_DATA_W 32

// Entries in the block RAM main store
// Must be a power of two
`define FIFO_DEPTH 512

// Main store almost_full rises when this many slots or fewer are free
`define FIFO_THRESHOLD 4

// Entries in the register FIFO behind the RAM
// Adds to the total capacity seen by the push side
`define OUT_FIFO_DEPTH 4

`endif
